// ==== src.f ====
+incdir+.
decode_pkg.sv
inst_decoder.sv
operand_select.sv
wb_port_scheduler.sv
issue_slot.sv
decode_control.sv
decode_stage.sv
tb_decode_stage.sv

// ==== tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Slot numbering used by the model
localparam int u_arith = 0;
localparam int u_mul   = 1;
localparam int u_div   = 2;
localparam int u_lsu   = 3;
localparam int u_none  = 4;

// Expected payloads in issue order, one queue per slot
decode_pkg::arith_issue_t exp_arith_q[$];
decode_pkg::mul_issue_t   exp_mul_q[$];
decode_pkg::div_issue_t   exp_div_q[$];
decode_pkg::lsu_issue_t   exp_lsu_q[$];

function automatic int classify_unit(input logic [31:0] w);
  logic [6:0] f7;
  logic [2:0] f3;
  int u;
  f7 = w[31:25];
  f3 = w[14:12];
  u = u_none;
  case (w[6:0])
    7'b0110011: begin
      if (f7 == 7'h01) u = f3[2] ? u_div : u_mul;
      else if (f7 == 7'h00) u = u_arith;
      else if (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) u = u_arith;
    end
    7'b0010011: begin
      // Shift immediates restrict the upper bits
      if (f3 == 3'd1) u = (f7 == 7'h00) ? u_arith : u_none;
      else if (f3 == 3'd5) u = (f7 == 7'h00 || f7 == 7'h20) ? u_arith : u_none;
      else u = u_arith;
    end
    7'b0110111, 7'b0010111: u = u_arith;
    7'b0000011: if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) u = u_lsu;
    7'b0100011: if (f3 inside {3'd0, 3'd1, 3'd2}) u = u_lsu;
    default: ;
  endcase
  return u;
endfunction

// Bit 0 is rs1, bit 1 is rs2
function automatic logic [1:0] used_regs(input logic [31:0] w);
  if (classify_unit(w) == u_none) return 2'b00;
  case (w[6:0])
    7'b0110011, 7'b0100011: return 2'b11;
    7'b0010011, 7'b0000011: return 2'b01;
    default: return 2'b00;
  endcase
endfunction

function automatic logic [31:0] select_a(input logic [31:0] w, input logic [31:0] pc,
                                         input logic [31:0] rs1v);
  case (w[6:0])
    7'b0110111: return 32'h0;
    7'b0010111: return pc;
    default: return rs1v;
  endcase
endfunction

function automatic logic [31:0] select_b(input logic [31:0] w, input logic [31:0] rs2v);
  case (w[6:0])
    7'b0110011: return rs2v;
    7'b0110111, 7'b0010111: return {w[31:12], 12'h000};
    7'b0100011: return {{20{w[31]}}, w[31:25], w[11:7]};
    default: return {{20{w[31]}}, w[31:20]};
  endcase
endfunction

// Zero means the instruction never touches the writeback port
function automatic int wb_latency(input int u, input logic [31:0] pa, input logic [31:0] pb);
  case (u)
    u_arith: return decode_pkg::lat_arith;
    u_mul: return decode_pkg::lat_mul;
    u_div: begin
      // Overflow and divide by zero finish early
      if (pa == 32'h8000_0000 || pb == 32'hffff_ffff || pb == 32'h0) begin
        return decode_pkg::lat_div_special;
      end
      return decode_pkg::lat_div;
    end
    default: return 0;
  endcase
endfunction

task automatic push_expected(input int u, input logic [31:0] w, input logic [31:0] pa,
                             input logic [31:0] pb, input logic [31:0] rs2v,
                             input logic [3:0] tag);
  decode_pkg::arith_issue_t a;
  decode_pkg::mul_issue_t   m;
  decode_pkg::div_issue_t   d;
  decode_pkg::lsu_issue_t   l;
  logic [3:0] alu;
  logic [4:0] rd;
  logic       is_store;
  is_store = (w[6:0] == 7'b0100011);
  rd = is_store ? 5'd0 : w[11:7];
  // Bit 30 reaches the ALU for OP and immediate right shifts only
  if (w[6:0] == 7'b0110011 || (w[6:0] == 7'b0010011 && w[14:12] == 3'd5)) begin
    alu = {w[30], w[14:12]};
  end else if (w[6:0] == 7'b0010011) begin
    alu = {1'b0, w[14:12]};
  end else begin
    alu = 4'h0;
  end
  a = '{alu_op: alu, port_a: pa, port_b: pb, rd: rd, tag: tag};
  m = '{funct3: w[14:12], port_a: pa, port_b: pb, rd: rd, tag: tag};
  d = '{funct3: w[14:12], port_a: pa, port_b: pb, rd: rd, tag: tag};
  l = '{is_store: is_store, funct3: w[14:12], base: pa, offset: pb, store_data: rs2v,
        rd: rd, tag: tag};
  case (u)
    u_arith: exp_arith_q.push_back(a);
    u_mul: exp_mul_q.push_back(m);
    u_div: exp_div_q.push_back(d);
    u_lsu: exp_lsu_q.push_back(l);
    default: ;
  endcase
endtask

`endif

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage;

  localparam int stim_cycles  = 2000;
  localparam int drain_cycles = 8;
  localparam int max_cycles   = 3 * stim_cycles;
  localparam int drive_dly    = 2;

  logic CLK;
  logic nRST;
  logic in_valid;
  decode_pkg::word_t in_instr;
  decode_pkg::word_t in_pc;
  logic in_ready;
  decode_pkg::reg_idx_t rs1_addr;
  decode_pkg::reg_idx_t rs2_addr;
  decode_pkg::word_t rs1_data;
  decode_pkg::word_t rs2_data;
  logic rs1_busy;
  logic rs2_busy;
  logic rs1_byp_en;
  decode_pkg::word_t rs1_byp_data;
  logic rs2_byp_en;
  decode_pkg::word_t rs2_byp_data;
  decode_pkg::tag_t cb_tail;
  logic cb_full;
  logic cb_alloc;
  logic arith_valid;
  logic arith_ready;
  decode_pkg::arith_issue_t arith_payload;
  logic mul_valid;
  logic mul_ready;
  decode_pkg::mul_issue_t mul_payload;
  logic div_valid;
  logic div_ready;
  decode_pkg::div_issue_t div_payload;
  logic lsu_valid;
  logic lsu_ready;
  decode_pkg::lsu_issue_t lsu_payload;

  integer seed = 32'h3766_bb9a;
  int errors = 0;
  int cycle_count = 0;
  logic [3:0] slot_full = 4'b0000;
  logic last_accept = 1'b0;
  // Reserved writeback cycles, indexed by stimulus cycle
  bit wb_taken [0:stim_cycles+drain_cycles+31];

  `include "tb_decode_model.svh"

  decode_stage dut0 (
    .CLK(CLK), .nRST(nRST), .in_valid(in_valid), .in_instr(in_instr), .in_pc(in_pc),
    .in_ready(in_ready), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
    .rs1_byp_en(rs1_byp_en), .rs1_byp_data(rs1_byp_data),
    .rs2_byp_en(rs2_byp_en), .rs2_byp_data(rs2_byp_data),
    .cb_tail(cb_tail), .cb_full(cb_full), .cb_alloc(cb_alloc),
    .arith_valid(arith_valid), .arith_ready(arith_ready), .arith_payload(arith_payload),
    .mul_valid(mul_valid), .mul_ready(mul_ready), .mul_payload(mul_payload),
    .div_valid(div_valid), .div_ready(div_ready), .div_payload(div_payload),
    .lsu_valid(lsu_valid), .lsu_ready(lsu_ready), .lsu_payload(lsu_payload)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  initial begin
    while (cycle_count < max_cycles) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", max_cycles);
    $display("Errors: %0d", errors);
    $display("** FAIL **");
    $finish;
  end

  task automatic report_mismatch(input string what, input logic [127:0] got,
                                 input logic [127:0] exp);
    errors++;
    $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
  endtask

  // Operand values with the divide corner cases mixed in
  function automatic logic [31:0] random_word();
    case ($random(seed) & 7)
      0: return 32'h8000_0000;
      1: return 32'hffff_ffff;
      2: return 32'h0;
      default: return $random(seed);
    endcase
  endfunction

  function automatic logic [31:0] random_instr();
    logic [31:0] w;
    logic [6:0]  f7;
    w = $random(seed);
    case ($random(seed) & 3)
      0: f7 = 7'h00;
      1: f7 = 7'h20;
      2: f7 = 7'h01;
      default: f7 = w[31:25];
    endcase
    case ($random(seed) & 7)
      0: w = {f7, w[24:7], 7'b0110011};
      1: w = {f7, w[24:7], 7'b0010011};
      2: w[6:0] = 7'b0110111;
      3: w[6:0] = 7'b0010111;
      4: w[6:0] = 7'b0000011;
      5: w[6:0] = 7'b0100011;
      6: w = {7'h01, w[24:7], 7'b0110011};
      // Fully random word, mostly unsupported
      default: ;
    endcase
    return w;
  endfunction

  task automatic drive_inputs(input bit stim_on);
    if (!stim_on) begin
      in_valid = 1'b0;
      {rs1_busy, rs2_busy, rs1_byp_en, rs2_byp_en, cb_full} = 5'b0;
      {arith_ready, mul_ready, div_ready, lsu_ready} = 4'b1111;
      return;
    end
    // Fetch holds its word until it is taken
    if (!in_valid || last_accept) begin
      in_valid = ($random(seed) & 7) != 0;
      in_instr = random_instr();
      in_pc = $random(seed) & 32'hffff_fffc;
    end
    rs1_data = random_word();
    rs2_data = random_word();
    rs1_busy = ($random(seed) & 3) == 0;
    rs2_busy = ($random(seed) & 3) == 0;
    rs1_byp_en = ($random(seed) & 3) == 0;
    rs2_byp_en = ($random(seed) & 3) == 0;
    rs1_byp_data = random_word();
    rs2_byp_data = random_word();
    cb_full = ($random(seed) & 15) == 0;
    cb_tail = $random(seed);
    arith_ready = ($random(seed) & 7) < 5;
    mul_ready = ($random(seed) & 7) < 5;
    div_ready = ($random(seed) & 7) < 5;
    lsu_ready = ($random(seed) & 7) < 5;
  endtask

  // Sampled mid-cycle, predicts what the coming edge does
  task automatic check_cycle(input int c);
    int u;
    int lat;
    logic [1:0]  uses;
    logic [31:0] rs1v;
    logic [31:0] rs2v;
    logic [31:0] pa;
    logic [31:0] pb;
    logic [3:0]  ready_v;
    logic [3:0]  valid_v;
    logic        exp_ready;
    logic        accepted;
    ready_v = {lsu_ready, div_ready, mul_ready, arith_ready};
    valid_v = {lsu_valid, div_valid, mul_valid, arith_valid};
    u = classify_unit(in_instr);
    uses = used_regs(in_instr);
    rs1v = rs1_byp_en ? rs1_byp_data : rs1_data;
    rs2v = rs2_byp_en ? rs2_byp_data : rs2_data;
    pa = select_a(in_instr, in_pc, rs1v);
    pb = select_b(in_instr, rs2v);
    lat = wb_latency(u, pa, pb);
    if (u == u_none) begin
      exp_ready = 1'b1;
    end else begin
      exp_ready = !cb_full && (!uses[0] || !rs1_busy || rs1_byp_en) &&
                  (!uses[1] || !rs2_busy || rs2_byp_en) &&
                  (!slot_full[u] || ready_v[u]) && !(lat > 0 && wb_taken[c + lat]);
    end
    accepted = in_valid && exp_ready;
    assert (in_ready === exp_ready) else report_mismatch("in_ready", in_ready, exp_ready);
    // Register file addresses are the rs1 and rs2 fields
    assert (rs1_addr === in_instr[19:15])
      else report_mismatch("rs1_addr", rs1_addr, in_instr[19:15]);
    assert (rs2_addr === in_instr[24:20])
      else report_mismatch("rs2_addr", rs2_addr, in_instr[24:20]);
    assert (cb_alloc === (accepted && u != u_none))
      else report_mismatch("cb_alloc", cb_alloc, accepted && u != u_none);
    for (int i = 0; i < 4; i++) begin
      assert (valid_v[i] === slot_full[i])
        else report_mismatch($sformatf("valid of slot %0d", i), valid_v[i], slot_full[i]);
    end
    // Held payloads compared every cycle, stalled or not
    if (slot_full[u_arith]) begin
      assert (arith_payload === exp_arith_q[0])
        else report_mismatch("arith payload", arith_payload, exp_arith_q[0]);
    end
    if (slot_full[u_mul]) begin
      assert (mul_payload === exp_mul_q[0])
        else report_mismatch("mul payload", mul_payload, exp_mul_q[0]);
    end
    if (slot_full[u_div]) begin
      assert (div_payload === exp_div_q[0])
        else report_mismatch("div payload", div_payload, exp_div_q[0]);
    end
    if (slot_full[u_lsu]) begin
      assert (lsu_payload === exp_lsu_q[0])
        else report_mismatch("lsu payload", lsu_payload, exp_lsu_q[0]);
    end
    if (in_valid && in_ready && u != u_none && lat > 0) begin
      assert (!wb_taken[c + lat]) else begin
        errors++;
        $display("Acceptance at %0t lands on a writeback cycle already reserved", $time);
      end
    end
    // Drains first, so a slot can reload in the same edge
    if (slot_full[u_arith] && arith_ready) void'(exp_arith_q.pop_front());
    if (slot_full[u_mul] && mul_ready) void'(exp_mul_q.pop_front());
    if (slot_full[u_div] && div_ready) void'(exp_div_q.pop_front());
    if (slot_full[u_lsu] && lsu_ready) void'(exp_lsu_q.pop_front());
    slot_full = slot_full & ~ready_v;
    if (accepted && u != u_none) begin
      if (lat > 0) wb_taken[c + lat] = 1'b1;
      push_expected(u, in_instr, pa, pb, rs2v, cb_tail);
      slot_full[u] = 1'b1;
    end
    last_accept = accepted;
  endtask

  initial begin
    nRST = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    in_pc = '0;
    {rs1_data, rs2_data, rs1_byp_data, rs2_byp_data} = '0;
    {rs1_busy, rs2_busy, rs1_byp_en, rs2_byp_en, cb_full} = 5'b0;
    cb_tail = '0;
    {arith_ready, mul_ready, div_ready, lsu_ready} = 4'b0000;
    repeat (10) begin
      @(negedge CLK);
      assert ({arith_valid, mul_valid, div_valid, lsu_valid, cb_alloc} === 5'b0)
        else report_mismatch("valids and cb_alloc in reset",
                             {arith_valid, mul_valid, div_valid, lsu_valid, cb_alloc}, 0);
    end
    @(posedge CLK);
    #drive_dly;
    nRST = 1'b1;
    for (int c = 0; c < stim_cycles + drain_cycles; c++) begin
      drive_inputs(c < stim_cycles);
      @(negedge CLK);
      check_cycle(c);
      @(posedge CLK);
      #drive_dly;
    end
    assert (exp_arith_q.size() + exp_mul_q.size() + exp_div_q.size() + exp_lsu_q.size() == 0)
      else begin
        errors++;
        $display("Accepted instructions were never delivered on their issue ports");
      end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  // Fetch side
  input  logic                     in_valid,
  input  decode_pkg::word_t        in_instr,
  input  decode_pkg::word_t        in_pc,
  output logic                     in_ready,
  // Register file and bypass
  output decode_pkg::reg_idx_t     rs1_addr,
  output decode_pkg::reg_idx_t     rs2_addr,
  input  decode_pkg::word_t        rs1_data,
  input  decode_pkg::word_t        rs2_data,
  input  logic                     rs1_busy,
  input  logic                     rs2_busy,
  input  logic                     rs1_byp_en,
  input  decode_pkg::word_t        rs1_byp_data,
  input  logic                     rs2_byp_en,
  input  decode_pkg::word_t        rs2_byp_data,
  // Completion buffer
  input  decode_pkg::tag_t         cb_tail,
  input  logic                     cb_full,
  output logic                     cb_alloc,
  // Issue ports
  output logic                     arith_valid,
  input  logic                     arith_ready,
  output decode_pkg::arith_issue_t arith_payload,
  output logic                     mul_valid,
  input  logic                     mul_ready,
  output decode_pkg::mul_issue_t   mul_payload,
  output logic                     div_valid,
  input  logic                     div_ready,
  output decode_pkg::div_issue_t   div_payload,
  output logic                     lsu_valid,
  input  logic                     lsu_ready,
  output decode_pkg::lsu_issue_t   lsu_payload
);

  decode_pkg::unit_t    unit;
  logic [2:0]           funct3;
  logic [3:0]           alu_op;
  decode_pkg::reg_idx_t rd;
  logic                 uses_rs1;
  logic                 uses_rs2;
  decode_pkg::src_a_t   src_a;
  decode_pkg::src_b_t   src_b;
  decode_pkg::word_t    imm_i;
  decode_pkg::word_t    imm_s;
  decode_pkg::word_t    imm_u;
  decode_pkg::word_t    port_a;
  decode_pkg::word_t    port_b;
  decode_pkg::word_t    store_data;
  logic                 accept;
  logic                 wb_conflict;
  logic                 arith_load;
  logic                 mul_load;
  logic                 div_load;
  logic                 lsu_load;
  logic                 arith_can_load;
  logic                 mul_can_load;
  logic                 div_can_load;
  logic                 lsu_can_load;

  decode_pkg::arith_issue_t arith_next;
  decode_pkg::mul_issue_t   mul_next;
  decode_pkg::div_issue_t   div_next;
  decode_pkg::lsu_issue_t   lsu_next;

  inst_decoder u_dec (
    .instr(in_instr), .unit(unit), .funct3(funct3), .alu_op(alu_op),
    .rs1_idx(rs1_addr), .rs2_idx(rs2_addr), .rd(rd),
    .uses_rs1(uses_rs1), .uses_rs2(uses_rs2), .src_a(src_a), .src_b(src_b),
    .imm_i(imm_i), .imm_s(imm_s), .imm_u(imm_u)
  );

  operand_select u_opsel (
    .pc(in_pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_byp_data(rs1_byp_data), .rs2_byp_data(rs2_byp_data),
    .rs1_byp_en(rs1_byp_en), .rs2_byp_en(rs2_byp_en), .src_a(src_a), .src_b(src_b),
    .imm_i(imm_i), .imm_s(imm_s), .imm_u(imm_u),
    .port_a(port_a), .port_b(port_b), .store_data(store_data)
  );

  wb_port_scheduler u_wb (
    .CLK(CLK), .nRST(nRST), .unit(unit), .port_a(port_a), .port_b(port_b),
    .accept(accept), .conflict(wb_conflict)
  );

  decode_control u_ctrl (
    .in_valid(in_valid), .unit(unit), .uses_rs1(uses_rs1), .uses_rs2(uses_rs2),
    .rs1_busy(rs1_busy), .rs2_busy(rs2_busy), .rs1_byp_en(rs1_byp_en),
    .rs2_byp_en(rs2_byp_en), .cb_full(cb_full), .wb_conflict(wb_conflict),
    .arith_can_load(arith_can_load), .mul_can_load(mul_can_load),
    .div_can_load(div_can_load), .lsu_can_load(lsu_can_load),
    .in_ready(in_ready), .accept(accept), .cb_alloc(cb_alloc),
    .arith_load(arith_load), .mul_load(mul_load), .div_load(div_load), .lsu_load(lsu_load)
  );

  // Payloads, tagged with the buffer tail at acceptance
  assign arith_next = '{alu_op: alu_op, port_a: port_a, port_b: port_b, rd: rd, tag: cb_tail};
  assign mul_next   = '{funct3: funct3, port_a: port_a, port_b: port_b, rd: rd, tag: cb_tail};
  assign div_next   = '{funct3: funct3, port_a: port_a, port_b: port_b, rd: rd, tag: cb_tail};
  assign lsu_next   = '{is_store: (src_b == decode_pkg::b_imm_s), funct3: funct3, base: port_a,
                        offset: port_b, store_data: store_data, rd: rd, tag: cb_tail};

  issue_slot #(.payload_t(decode_pkg::arith_issue_t)) slot_arith (
    .CLK(CLK), .nRST(nRST), .load(arith_load), .load_data(arith_next),
    .out_ready(arith_ready), .out_valid(arith_valid), .out_payload(arith_payload),
    .can_load(arith_can_load)
  );

  issue_slot #(.payload_t(decode_pkg::mul_issue_t)) slot_mul (
    .CLK(CLK), .nRST(nRST), .load(mul_load), .load_data(mul_next),
    .out_ready(mul_ready), .out_valid(mul_valid), .out_payload(mul_payload),
    .can_load(mul_can_load)
  );

  issue_slot #(.payload_t(decode_pkg::div_issue_t)) slot_div (
    .CLK(CLK), .nRST(nRST), .load(div_load), .load_data(div_next),
    .out_ready(div_ready), .out_valid(div_valid), .out_payload(div_payload),
    .can_load(div_can_load)
  );

  issue_slot #(.payload_t(decode_pkg::lsu_issue_t)) slot_lsu (
    .CLK(CLK), .nRST(nRST), .load(lsu_load), .load_data(lsu_next),
    .out_ready(lsu_ready), .out_valid(lsu_valid), .out_payload(lsu_payload),
    .can_load(lsu_can_load)
  );

endmodule

// ==== decode_control.sv ====
`timescale 1ns/1ps

module decode_control (
  input  logic              in_valid,
  input  decode_pkg::unit_t unit,
  input  logic              uses_rs1,
  input  logic              uses_rs2,
  input  logic              rs1_busy,
  input  logic              rs2_busy,
  input  logic              rs1_byp_en,
  input  logic              rs2_byp_en,
  input  logic              cb_full,
  input  logic              wb_conflict,
  input  logic              arith_can_load,
  input  logic              mul_can_load,
  input  logic              div_can_load,
  input  logic              lsu_can_load,
  output logic              in_ready,
  output logic              accept,
  output logic              cb_alloc,
  output logic              arith_load,
  output logic              mul_load,
  output logic              div_load,
  output logic              lsu_load
);

  logic rs1_ok;
  logic rs2_ok;
  logic slot_free;
  logic supported;

  // A bypass clears the busy state of that operand
  assign rs1_ok = !uses_rs1 || !rs1_busy || rs1_byp_en;
  assign rs2_ok = !uses_rs2 || !rs2_busy || rs2_byp_en;

  always_comb begin
    case (unit)
      decode_pkg::unit_arith: slot_free = arith_can_load;
      decode_pkg::unit_mul:   slot_free = mul_can_load;
      decode_pkg::unit_div:   slot_free = div_can_load;
      decode_pkg::unit_lsu:   slot_free = lsu_can_load;
      default:                slot_free = 1'b1;
    endcase
  end

  assign supported = (unit != decode_pkg::unit_none);

  // Unsupported words are always taken and dropped
  assign in_ready = !supported ||
                    (!cb_full && rs1_ok && rs2_ok && slot_free && !wb_conflict);

  assign accept   = in_valid && in_ready;
  assign cb_alloc = accept && supported;

  assign arith_load = accept && (unit == decode_pkg::unit_arith);
  assign mul_load   = accept && (unit == decode_pkg::unit_mul);
  assign div_load   = accept && (unit == decode_pkg::unit_div);
  assign lsu_load   = accept && (unit == decode_pkg::unit_lsu);

endmodule

// ==== issue_slot.sv ====
`timescale 1ns/1ps

module issue_slot #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     load,
  input  payload_t load_data,
  input  logic     out_ready,
  output logic     out_valid,
  output payload_t out_payload,
  output logic     can_load
);

  // Empty, or the held entry leaves this cycle
  assign can_load = !out_valid || out_ready;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      out_payload <= load_data;
    end
  end

  // Held entry must survive back-pressure untouched
  assert property (@(posedge CLK) disable iff (!nRST)
    out_valid && !out_ready |=> out_valid && $stable(out_payload))
    else $error("issue payload changed under back-pressure");

endmodule

// ==== wb_port_scheduler.sv ====
`timescale 1ns/1ps

module wb_port_scheduler (
  input  logic              CLK,
  input  logic              nRST,
  input  decode_pkg::unit_t unit,
  input  decode_pkg::word_t port_a,
  input  decode_pkg::word_t port_b,
  input  logic              accept,
  output logic              conflict
);

  // Bit i set means the writeback port is taken i edges after the next one
  logic [decode_pkg::wb_window-1:0] resv_q;
  logic [decode_pkg::wb_window-1:0] need;
  logic [decode_pkg::wb_window-1:0] resv_next;
  logic                             div_special;

  // Overflow and divide by zero finish early
  assign div_special = (port_a == decode_pkg::div_int_min) ||
                       (port_b == '1) || (port_b == '0);

  always_comb begin
    need = '0;
    case (unit)
      decode_pkg::unit_arith: need[decode_pkg::lat_arith] = 1'b1;
      decode_pkg::unit_mul:   need[decode_pkg::lat_mul] = 1'b1;
      decode_pkg::unit_div: begin
        if (div_special) need[decode_pkg::lat_div_special] = 1'b1;
        else need[decode_pkg::lat_div] = 1'b1;
      end
      // Loads, stores and discarded words never use the port
      default: need = '0;
    endcase
  end

  assign conflict = |(resv_q & need);

  assign resv_next = accept ? (resv_q | need) : resv_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      resv_q <= '0;
    end else begin
      resv_q <= resv_next >> 1;
    end
  end

  // Control must hold back anything that collides on the port
  assert property (@(posedge CLK) disable iff (!nRST) accept |-> !conflict)
    else $error("writeback port double booked");

endmodule

// ==== operand_select.sv ====
`timescale 1ns/1ps

module operand_select (
  input  decode_pkg::word_t  pc,
  input  decode_pkg::word_t  rs1_data,
  input  decode_pkg::word_t  rs2_data,
  input  decode_pkg::word_t  rs1_byp_data,
  input  decode_pkg::word_t  rs2_byp_data,
  input  logic               rs1_byp_en,
  input  logic               rs2_byp_en,
  input  decode_pkg::src_a_t src_a,
  input  decode_pkg::src_b_t src_b,
  input  decode_pkg::word_t  imm_i,
  input  decode_pkg::word_t  imm_s,
  input  decode_pkg::word_t  imm_u,
  output decode_pkg::word_t  port_a,
  output decode_pkg::word_t  port_b,
  output decode_pkg::word_t  store_data
);

  decode_pkg::word_t rs1_val;
  decode_pkg::word_t rs2_val;

  // Bypass has priority over the register file
  assign rs1_val = rs1_byp_en ? rs1_byp_data : rs1_data;
  assign rs2_val = rs2_byp_en ? rs2_byp_data : rs2_data;

  always_comb begin
    case (src_a)
      decode_pkg::a_rs1:  port_a = rs1_val;
      decode_pkg::a_pc:   port_a = pc;
      decode_pkg::a_zero: port_a = '0;
      default:            port_a = '0;
    endcase
  end

  // Shifts take shamt from the low imm_i bits
  always_comb begin
    case (src_b)
      decode_pkg::b_rs2:   port_b = rs2_val;
      decode_pkg::b_imm_i: port_b = imm_i;
      decode_pkg::b_imm_u: port_b = imm_u;
      decode_pkg::b_imm_s: port_b = imm_s;
      default:             port_b = '0;
    endcase
  end

  // Store data always from rs2
  assign store_data = rs2_val;

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/1ps

module inst_decoder (
  input  decode_pkg::word_t    instr,
  output decode_pkg::unit_t    unit,
  output logic [2:0]           funct3,
  output logic [3:0]           alu_op,
  output decode_pkg::reg_idx_t rs1_idx,
  output decode_pkg::reg_idx_t rs2_idx,
  output decode_pkg::reg_idx_t rd,
  output logic                 uses_rs1,
  output logic                 uses_rs2,
  output decode_pkg::src_a_t   src_a,
  output decode_pkg::src_b_t   src_b,
  output decode_pkg::word_t    imm_i,
  output decode_pkg::word_t    imm_s,
  output decode_pkg::word_t    imm_u
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];

  // Stores write no register, bits 11:7 are immediate there
  assign rd = (opcode == decode_pkg::opc_store) ? '0 : instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  assign f7_zero = (funct7 == 7'b0000000);
  // SUB and SRA/SRAI encoding
  assign f7_alt  = (funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101);

  always_comb begin
    unit     = decode_pkg::unit_none;
    alu_op   = {1'b0, funct3};
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    src_a    = decode_pkg::a_rs1;
    src_b    = decode_pkg::b_rs2;
    case (opcode)
      decode_pkg::opc_op: begin
        if (funct7 == decode_pkg::funct7_muldiv) begin
          // funct3[2] splits divide/remainder from multiply
          unit = funct3[2] ? decode_pkg::unit_div : decode_pkg::unit_mul;
        end else if (f7_zero || f7_alt) begin
          unit = decode_pkg::unit_arith;
        end
        alu_op   = {instr[30], funct3};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      decode_pkg::opc_op_imm: begin
        // Bit 30 only matters for right shifts
        if (funct3 == 3'b101) begin
          alu_op = {instr[30], funct3};
          if (f7_zero || f7_alt) unit = decode_pkg::unit_arith;
        end else if (funct3 == 3'b001) begin
          if (f7_zero) unit = decode_pkg::unit_arith;
        end else begin
          unit = decode_pkg::unit_arith;
        end
        uses_rs1 = 1'b1;
        src_b    = decode_pkg::b_imm_i;
      end
      decode_pkg::opc_lui: begin
        unit   = decode_pkg::unit_arith;
        alu_op = 4'b0000;
        src_a  = decode_pkg::a_zero;
        src_b  = decode_pkg::b_imm_u;
      end
      decode_pkg::opc_auipc: begin
        unit   = decode_pkg::unit_arith;
        alu_op = 4'b0000;
        src_a  = decode_pkg::a_pc;
        src_b  = decode_pkg::b_imm_u;
      end
      decode_pkg::opc_load: begin
        // LB, LH, LW, LBU, LHU
        if (funct3 != 3'b011 && funct3[2:1] != 2'b11) unit = decode_pkg::unit_lsu;
        uses_rs1 = 1'b1;
        src_b    = decode_pkg::b_imm_i;
      end
      decode_pkg::opc_store: begin
        if (funct3[2] == 1'b0 && funct3 != 3'b011) unit = decode_pkg::unit_lsu;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        src_b    = decode_pkg::b_imm_s;
      end
      default: ;
    endcase
    // Discarded encodings read nothing
    if (unit == decode_pkg::unit_none) begin
      uses_rs1 = 1'b0;
      uses_rs2 = 1'b0;
    end
  end

endmodule

// ==== decode_pkg.sv ====
package decode_pkg;

  // Widths
  localparam int xlen      = 32;
  localparam int reg_idx_w = 5;
  localparam int tag_w     = 4;

  typedef logic [xlen-1:0]      word_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [tag_w-1:0]     tag_t;

  // Writeback latency in cycles, counted from the accepting edge
  localparam int lat_arith       = 1;
  localparam int lat_mul         = 4;
  localparam int lat_div         = 18;
  localparam int lat_div_special = 1;
  localparam int wb_window       = 19;

  // Major opcodes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // Most negative integer, divide overflow case
  localparam word_t div_int_min = 32'h8000_0000;

  typedef enum logic [2:0] {
    unit_arith,
    unit_mul,
    unit_div,
    unit_lsu,
    unit_none
  } unit_t;

  typedef enum logic [1:0] {
    a_rs1,
    a_pc,
    a_zero
  } src_a_t;

  // Shift amounts come out of imm_i
  typedef enum logic [1:0] {
    b_rs2,
    b_imm_i,
    b_imm_u,
    b_imm_s
  } src_b_t;

  // Issue payloads, one per slot
  typedef struct packed {
    logic [3:0] alu_op;
    word_t      port_a;
    word_t      port_b;
    reg_idx_t   rd;
    tag_t       tag;
  } arith_issue_t;

  typedef struct packed {
    logic [2:0] funct3;
    word_t      port_a;
    word_t      port_b;
    reg_idx_t   rd;
    tag_t       tag;
  } mul_issue_t;

  typedef struct packed {
    logic [2:0] funct3;
    word_t      port_a;
    word_t      port_b;
    reg_idx_t   rd;
    tag_t       tag;
  } div_issue_t;

  typedef struct packed {
    logic       is_store;
    logic [2:0] funct3;
    word_t      base;
    word_t      offset;
    word_t      store_data;
    reg_idx_t   rd;
    tag_t       tag;
  } lsu_issue_t;

endpackage
